// ==== logic/phy_mgmt_defines.svh ====
// phy management defines: bus address, MDC timing and init sequence constants

`ifndef PHY_MGMT_DEFINES_SVH
`define PHY_MGMT_DEFINES_SVH

// clause-22 bus address of the PHY on the board
`define PHY_MDIO_ADDR 3

// system clocks per MDC phase
// 125 MHz / (2 * 3) is about 20.8 MHz, under the 25 MHz PHY limit
`define MDC_HALF_PERIOD_CYCLES 3

// power-on wait in system clocks, all twenty counter bits set
`define PHY_INIT_DELAY_DEFAULT 20'd1048575

// three indirect writes of four direct writes each
`define INIT_WRITE_COUNT 12

`endif

// ==== logic/phy_mgmt_pkg.sv ====
// phy management package: width types and sequencer states

`default_nettype none

package phy_mgmt_pkg;

    // direct clause-22 register address
    typedef logic [4:0] mdio_reg_addr_t;

    // PHY address on the management bus
    typedef logic [4:0] phy_addr_t;

    // register data word
    typedef logic [15:0] mdio_data_t;

    // index of a direct write in the init sequence
    typedef logic [3:0] init_step_t;

    // power-on delay counter
    typedef logic [19:0] delay_count_t;

    // init sequencer FSM
    typedef enum logic [1:0] {
        wait_delay,
        issue,
        wait_frame,
        done
    } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/phy_init_delay.sv ====
// phy init delay: counts the power-on wait after reset and flags its end

`timescale 1ns/100ps
`default_nettype none

module phy_init_delay #(
    parameter phy_mgmt_pkg::delay_count_t init_delay_cycles = 20'd100
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,
    output wire logic delay_done
);

    import phy_mgmt_pkg::*;

    delay_count_t count_reg;

    // counts down once reset is released and parks at zero
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            count_reg <= init_delay_cycles;
        end else if (count_reg != '0) begin
            count_reg <= count_reg - 1'b1;
        end
    end

    // high from the cycle the count reaches zero onwards
    assign delay_done = (count_reg == '0);

endmodule

`default_nettype wire

// ==== logic/phy_ext_reg_table.sv ====
// phy extended register table: maps a step number to its direct register write

`timescale 1ns/100ps
`default_nettype none

module phy_ext_reg_table (
    input  wire phy_mgmt_pkg::init_step_t     step,
    output wire phy_mgmt_pkg::mdio_reg_addr_t reg_addr,
    output wire phy_mgmt_pkg::mdio_data_t     reg_data
);

    import phy_mgmt_pkg::*;

    // indirect access registers
    localparam mdio_reg_addr_t regcr = 5'h0D;
    localparam mdio_reg_addr_t addar = 5'h0E;

    // REGCR words: devad 0x1F, function address then data without increment
    localparam mdio_data_t regcr_addr_func = 16'h001F;
    localparam mdio_data_t regcr_data_func = 16'h401F;

    logic [1:0] access;
    logic [1:0] phase;
    mdio_data_t ext_addr;
    mdio_data_t ext_data;
    mdio_reg_addr_t addr_sel;
    mdio_data_t data_sel;

    // four direct writes per extended register
    assign access = step[3:2];
    assign phase  = step[1:0];

    always_comb begin
        case (access)
            // autonegotiation timer, 11 ms
            2'd0: begin
                ext_addr = 16'h0031;
                ext_data = 16'h0070;
            end
            // SGMII clock output on
            2'd1: begin
                ext_addr = 16'h00D3;
                ext_data = 16'h4000;
            end
            // 10 Mb/s over SGMII
            2'd2: begin
                ext_addr = 16'h016F;
                ext_data = 16'h0015;
            end
            default: begin
                ext_addr = '0;
                ext_data = '0;
            end
        endcase
    end

    always_comb begin
        case (phase)
            2'd0: begin
                addr_sel = regcr;
                data_sel = regcr_addr_func;
            end
            2'd1: begin
                addr_sel = addar;
                data_sel = ext_addr;
            end
            2'd2: begin
                addr_sel = regcr;
                data_sel = regcr_data_func;
            end
            default: begin
                addr_sel = addar;
                data_sel = ext_data;
            end
        endcase
    end

    assign reg_addr = addr_sel;
    assign reg_data = data_sel;

endmodule

`default_nettype wire

// ==== logic/mdio_clock_gen.sv ====
// mdio clock generator: divides the system clock into MDC with edge strobes

`timescale 1ns/100ps
`default_nettype none

`include "phy_mgmt_defines.svh"

module mdio_clock_gen (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,
    input  wire logic enable,
    output wire logic mdc,
    output wire logic mdc_rise,
    output wire logic mdc_fall
);

    localparam int half_cycles = `MDC_HALF_PERIOD_CYCLES;
    localparam int cnt_w = $clog2(half_cycles + 1);

    logic [cnt_w-1:0] phase_cnt;
    logic             mdc_reg;
    logic             phase_start;

    // idle parks in the low phase, so a new frame opens with a fall strobe
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz || !enable) begin
            phase_cnt <= '0;
            mdc_reg   <= 1'b0;
        end else if (phase_cnt == cnt_w'(half_cycles - 1)) begin
            phase_cnt <= '0;
            mdc_reg   <= !mdc_reg;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // strobe on the first cycle of each phase
    assign phase_start = enable && (phase_cnt == '0);

    assign mdc_fall = phase_start && !mdc_reg;
    assign mdc_rise = phase_start && mdc_reg;
    assign mdc      = mdc_reg;

endmodule

`default_nettype wire

// ==== logic/mdio_write_shifter.sv ====
// mdio write shifter: serializes one clause-22 write frame onto MDIO

`timescale 1ns/100ps
`default_nettype none

`include "phy_mgmt_defines.svh"

module mdio_write_shifter (
    input  wire logic                        clk_125mhz,
    input  wire logic                        rst_125mhz,
    input  wire logic                        frame_start,
    input  wire phy_mgmt_pkg::mdio_reg_addr_t reg_addr,
    input  wire phy_mgmt_pkg::mdio_data_t     reg_data,
    output wire logic                        frame_busy,
    output wire logic                        mdc,
    output wire logic                        mdio_o,
    output wire logic                        mdio_t
);

    import phy_mgmt_pkg::*;

    localparam int frame_bits = 64;
    localparam phy_addr_t phy_addr = phy_addr_t'(`PHY_MDIO_ADDR);

    logic [frame_bits-1:0] shift_reg;
    logic [frame_bits-1:0] frame_word;
    logic [6:0]            bit_cnt;
    logic                  busy_reg;
    logic                  mdio_o_reg;
    logic                  mdio_t_reg;
    logic                  load;
    logic                  mdc_rise;
    logic                  mdc_fall;

    mdio_clock_gen mdio_clock_gen_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .enable     (busy_reg),
        .mdc        (mdc),
        .mdc_rise   (mdc_rise),
        .mdc_fall   (mdc_fall)
    );

    // preamble, start 01, write op 01, addresses, turnaround 10, data
    assign frame_word = {32'hFFFF_FFFF, 2'b01, 2'b01, phy_addr, reg_addr, 2'b10, reg_data};

    assign load = frame_start && !busy_reg;

    // frame data, shifted MSB first
    always_ff @(posedge clk_125mhz) begin
        if (load) begin
            shift_reg <= frame_word;
        end else if (busy_reg && mdc_fall) begin
            shift_reg <= {shift_reg[frame_bits-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            busy_reg   <= 1'b0;
            bit_cnt    <= '0;
            mdio_o_reg <= 1'b1;
            mdio_t_reg <= 1'b1;
        end else if (load) begin
            busy_reg <= 1'b1;
            bit_cnt  <= '0;
        end else if (busy_reg) begin
            if (mdc_fall) begin
                if (bit_cnt == 7'(frame_bits)) begin
                    // last bit period over, release the bus
                    busy_reg   <= 1'b0;
                    mdio_o_reg <= 1'b1;
                    mdio_t_reg <= 1'b1;
                end else begin
                    mdio_o_reg <= shift_reg[frame_bits-1];
                    mdio_t_reg <= 1'b0;
                end
            end
            // bits taken by the PHY on the rising edge
            if (mdc_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign frame_busy = busy_reg;
    assign mdio_o     = mdio_o_reg;
    assign mdio_t     = mdio_t_reg;

endmodule

`default_nettype wire

// ==== logic/phy_init_sequencer.sv ====
// phy init sequencer: FSM that walks the register table and starts each frame

`timescale 1ns/100ps
`default_nettype none

`include "phy_mgmt_defines.svh"

module phy_init_sequencer (
    input  wire logic                    clk_125mhz,
    input  wire logic                    rst_125mhz,
    input  wire logic                    delay_done,
    input  wire logic                    frame_busy,
    output wire phy_mgmt_pkg::init_step_t step,
    output wire logic                    frame_start,
    output wire logic                    init_done
);

    import phy_mgmt_pkg::*;

    localparam init_step_t last_step = init_step_t'(`INIT_WRITE_COUNT - 1);

    seq_state_t state_reg;
    init_step_t step_reg;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state_reg <= wait_delay;
            step_reg  <= '0;
        end else begin
            case (state_reg)
                wait_delay: begin
                    if (delay_done) begin
                        state_reg <= issue;
                    end
                end
                issue: begin
                    // frame_start goes out on this cycle once the shifter is idle
                    if (!frame_busy) begin
                        state_reg <= wait_frame;
                    end
                end
                wait_frame: begin
                    if (!frame_busy) begin
                        if (step_reg == last_step) begin
                            state_reg <= done;
                        end else begin
                            step_reg  <= step_reg + 1'b1;
                            state_reg <= issue;
                        end
                    end
                end
                done: begin
                    state_reg <= done;
                end
                default: begin
                    state_reg <= wait_delay;
                end
            endcase
        end
    end

    // one-cycle start, busy rises on the next cycle
    assign frame_start = (state_reg == issue) && !frame_busy;
    assign init_done   = (state_reg == done);
    assign step        = step_reg;

endmodule

`default_nettype wire

// ==== logic/phy_mgmt_top.sv ====
// phy management top: holds the PHY in reset, then writes its init registers over MDIO

`timescale 1ns/100ps
`default_nettype none

`include "phy_mgmt_defines.svh"

module phy_mgmt_top #(
    parameter phy_mgmt_pkg::delay_count_t init_delay_cycles = `PHY_INIT_DELAY_DEFAULT
) (
    input  wire logic clk_125mhz,
    input  wire logic rst_125mhz,
    output wire logic phy_reset_n,
    output wire logic phy_mdc,
    output wire logic phy_mdio_o,
    output wire logic phy_mdio_t,
    output wire logic init_done
);

    import phy_mgmt_pkg::*;

    logic           delay_done;
    logic           frame_busy;
    logic           frame_start;
    init_step_t     step;
    mdio_reg_addr_t reg_addr;
    mdio_data_t     reg_data;

    // PHY leaves reset together with the system
    assign phy_reset_n = !rst_125mhz;

    phy_init_delay #(
        .init_delay_cycles (init_delay_cycles)
    ) phy_init_delay_inst (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .delay_done (delay_done)
    );

    phy_init_sequencer phy_init_sequencer_inst (
        .clk_125mhz  (clk_125mhz),
        .rst_125mhz  (rst_125mhz),
        .delay_done  (delay_done),
        .frame_busy  (frame_busy),
        .step        (step),
        .frame_start (frame_start),
        .init_done   (init_done)
    );

    phy_ext_reg_table phy_ext_reg_table_inst (
        .step     (step),
        .reg_addr (reg_addr),
        .reg_data (reg_data)
    );

    mdio_write_shifter mdio_write_shifter_inst (
        .clk_125mhz  (clk_125mhz),
        .rst_125mhz  (rst_125mhz),
        .frame_start (frame_start),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .frame_busy  (frame_busy),
        .mdc         (phy_mdc),
        .mdio_o      (phy_mdio_o),
        .mdio_t      (phy_mdio_t)
    );

endmodule

`default_nettype wire

// ==== test/mdio_frame_monitor.sv ====
// mdio frame monitor: samples MDIO on rising MDC and decodes whole 64-bit frames

`timescale 1ns/100ps
`default_nettype none

module mdio_frame_monitor (
    input  wire logic  clk_125mhz,
    input  wire logic  rst_125mhz,
    input  wire logic  mdc,
    input  wire logic  mdio_o,
    input  wire logic  mdio_t,
    output logic        frame_valid,
    output logic [63:0] frame_data,
    output logic        framing_error
);

    logic        mdc_prev;
    logic [63:0] shift_reg;
    logic [6:0]  bit_cnt;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            mdc_prev      <= 1'b0;
            shift_reg     <= '0;
            bit_cnt       <= '0;
            frame_valid   <= 1'b0;
            frame_data    <= '0;
            framing_error <= 1'b0;
        end else begin
            mdc_prev      <= mdc;
            frame_valid   <= 1'b0;
            framing_error <= 1'b0;
            if (mdc && !mdc_prev) begin
                if (!mdio_t) begin
                    // PHY side view: bit taken on the rising edge
                    shift_reg <= {shift_reg[62:0], mdio_o};
                    if (bit_cnt == 7'd63) begin
                        frame_valid <= 1'b1;
                        frame_data  <= {shift_reg[62:0], mdio_o};
                        bit_cnt     <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end else begin
                    // clock edge with the bus released
                    framing_error <= 1'b1;
                end
            end else if (mdio_t && bit_cnt != 7'd0) begin
                // bus released in the middle of a frame
                framing_error <= 1'b1;
                bit_cnt       <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/phy_mgmt_tb.sv ====
// phy management testbench for reset state, power-on wait and the twelve MDIO init frames

`timescale 1ns/100ps
`default_nettype none

`include "phy_mgmt_defines.svh"

module phy_mgmt_tb;

    localparam int delay_cycles   = 100;
    localparam int frame_count    = `INIT_WRITE_COUNT;
    // power-on wait, frames of about 390 clocks, tail check and margin
    localparam int timeout_cycles = delay_cycles + frame_count * 400 + 1100;

    logic        clk_125mhz;
    logic        rst_125mhz;
    wire logic   phy_reset_n;
    wire logic   phy_mdc;
    wire logic   phy_mdio_o;
    wire logic   phy_mdio_t;
    wire logic   init_done;
    logic        frame_valid;
    logic [63:0] frame_data;
    logic        framing_error;

    logic [4:0]  expected_addr [$];
    logic [15:0] expected_data [$];
    int          test_errors [1:6];
    int          frames_seen;
    int          cycle_count = 0;
    int          phase_len;
    logic        phase_full;
    logic        prev_mdc;
    logic        prev_mdio_o;

    phy_mgmt_top #(
        .init_delay_cycles (20'(delay_cycles))
    ) uut (
        .clk_125mhz  (clk_125mhz),
        .rst_125mhz  (rst_125mhz),
        .phy_reset_n (phy_reset_n),
        .phy_mdc     (phy_mdc),
        .phy_mdio_o  (phy_mdio_o),
        .phy_mdio_t  (phy_mdio_t),
        .init_done   (init_done)
    );

    mdio_frame_monitor monitor (
        .clk_125mhz    (clk_125mhz),
        .rst_125mhz    (rst_125mhz),
        .mdc           (phy_mdc),
        .mdio_o        (phy_mdio_o),
        .mdio_t        (phy_mdio_t),
        .frame_valid   (frame_valid),
        .frame_data    (frame_data),
        .framing_error (framing_error)
    );

    always #4 clk_125mhz = !clk_125mhz;

    task automatic check_value(input int test_id, input string name,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected) else begin
            test_errors[test_id]++;
            $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input int test_id, input logic cond, input string what);
        assert (cond === 1'b1) else begin
            test_errors[test_id]++;
            $display("Error at %0d ns: %s", $time, what);
        end
    endtask

    task automatic report_test(input int test_id, input string name);
        $display("test %0d %s: %s, %0d errors", test_id, name,
                 (test_errors[test_id] == 0) ? "ok" : "FAILED", test_errors[test_id]);
    endtask

    task automatic add_expected_write(input logic [4:0] addr, input logic [15:0] data);
        expected_addr.push_back(addr);
        expected_data.push_back(data);
    endtask

    // REGCR 0x001F, ADDAR address, REGCR 0x401F and ADDAR data per indirect write
    task automatic build_expected_list();
        logic [15:0] ext_addr [3];
        logic [15:0] ext_data [3];
        ext_addr[0] = 16'h0031;
        ext_data[0] = 16'h0070;
        ext_addr[1] = 16'h00D3;
        ext_data[1] = 16'h4000;
        ext_addr[2] = 16'h016F;
        ext_data[2] = 16'h0015;
        for (int i = 0; i < 3; i++) begin
            add_expected_write(5'h0D, 16'h001F);
            add_expected_write(5'h0E, ext_addr[i]);
            add_expected_write(5'h0D, 16'h401F);
            add_expected_write(5'h0E, ext_data[i]);
        end
    endtask

    always @(posedge clk_125mhz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: init sequence not finished after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    // frame fields and contents
    always @(negedge clk_125mhz) begin
        if (framing_error) begin
            check_true(3, 1'b0, "malformed frame decoded from MDIO");
        end
        if (frame_valid) begin
            check_value(3, "preamble", 64'h0000_0000_FFFF_FFFF, 64'(frame_data[63:32]));
            check_value(3, "start", 64'(2'b01), 64'(frame_data[31:30]));
            check_value(3, "op", 64'(2'b01), 64'(frame_data[29:28]));
            check_value(3, "phy_addr", 64'(`PHY_MDIO_ADDR), 64'(frame_data[27:23]));
            check_value(3, "turnaround", 64'(2'b10), 64'(frame_data[17:16]));
            if (frames_seen < frame_count) begin
                check_value(4, "reg_addr", 64'(expected_addr[frames_seen]),
                            64'(frame_data[22:18]));
                check_value(4, "reg_data", 64'(expected_data[frames_seen]),
                            64'(frame_data[15:0]));
            end else begin
                check_true(4, 1'b0, "frame seen after the last init write");
            end
            frames_seen++;
        end
    end

    // MDC phase lengths and MDIO change points while the bus is driven
    always @(negedge clk_125mhz) begin
        if (rst_125mhz) begin
            prev_mdc    = 1'b0;
            prev_mdio_o = 1'b1;
            phase_len   = 0;
            phase_full  = 1'b0;
        end else begin
            if (!phy_mdio_t && phy_mdio_o !== prev_mdio_o) begin
                check_true(5, !phy_mdc, "mdio_o changed while mdc was high");
            end
            if (phy_mdc !== prev_mdc) begin
                if (phase_full) begin
                    check_value(5, "mdc phase length", 64'(3), 64'(phase_len));
                end
                phase_len  = 1;
                phase_full = !phy_mdio_t;
            end else begin
                phase_len++;
                if (phy_mdio_t) begin
                    phase_full = 1'b0;
                end
            end
            prev_mdc    = phy_mdc;
            prev_mdio_o = phy_mdio_o;
        end
    end

    initial begin
        int total;
        clk_125mhz  = 1'b0;
        rst_125mhz  = 1'b1;
        frames_seen = 0;
        total       = 0;
        for (int i = 1; i <= 6; i++) begin
            test_errors[i] = 0;
        end
        build_expected_list();

        // reset held for three rising edges
        repeat (2) @(negedge clk_125mhz);
        check_value(1, "phy_reset_n", 64'(0), 64'(phy_reset_n));
        check_value(1, "mdio_t", 64'(1), 64'(phy_mdio_t));
        check_value(1, "mdc", 64'(0), 64'(phy_mdc));
        check_value(1, "init_done", 64'(0), 64'(init_done));
        @(negedge clk_125mhz);
        rst_125mhz = 1'b0;
        @(negedge clk_125mhz);
        check_value(1, "phy_reset_n", 64'(1), 64'(phy_reset_n));
        check_value(1, "mdio_t", 64'(1), 64'(phy_mdio_t));
        check_value(1, "mdc", 64'(0), 64'(phy_mdc));
        check_value(1, "init_done", 64'(0), 64'(init_done));
        report_test(1, "reset values");

        // bus quiet through the power-on wait
        repeat (delay_cycles - 1) begin
            @(negedge clk_125mhz);
            check_value(2, "mdio_t", 64'(1), 64'(phy_mdio_t));
            check_value(2, "mdc", 64'(0), 64'(phy_mdc));
        end
        report_test(2, "power-on wait");

        while (!init_done) begin
            @(negedge clk_125mhz);
        end
        check_value(4, "frame count", 64'(frame_count), 64'(frames_seen));
        report_test(3, "frame fields");
        report_test(4, "register writes");
        report_test(5, "mdc timing");

        // bus stays idle once init is over
        repeat (200) begin
            @(negedge clk_125mhz);
            check_value(6, "mdc", 64'(0), 64'(phy_mdc));
            check_value(6, "mdio_t", 64'(1), 64'(phy_mdio_t));
            check_value(6, "init_done", 64'(1), 64'(init_done));
        end
        report_test(6, "idle after init");

        for (int i = 1; i <= 6; i++) begin
            total += test_errors[i];
        end
        $display("summary: 6 tests, %0d frames, %0d errors", frames_seen, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/phy_mgmt_pkg.sv
logic/phy_init_delay.sv
logic/phy_ext_reg_table.sv
logic/mdio_clock_gen.sv
logic/mdio_write_shifter.sv
logic/phy_init_sequencer.sv
logic/phy_mgmt_top.sv
test/mdio_frame_monitor.sv
test/phy_mgmt_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = phy_mgmt_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
